/* logic/id_free_list.sv */
`timescale 1ns/1ps

module id_free_list #(
   parameter int LOG_COUNT = 2
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 put_en,
   input  logic [LOG_COUNT-1:0] put_id,
   input  logic                 take_en,
   output logic [LOG_COUNT-1:0] next_id,
   output logic                 empty
);

   localparam int COUNT = 1 << LOG_COUNT;

   logic [LOG_COUNT-1:0] ids [COUNT];
   logic [LOG_COUNT-1:0] head;
   logic [LOG_COUNT-1:0] tail;
   logic [LOG_COUNT:0]   count;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < COUNT; i++) begin
            ids[i] <= LOG_COUNT'(i);   // Every identifier starts out free
         end
         head  <= '0;
         tail  <= '0;
         count <= (LOG_COUNT+1)'(COUNT);
      end else begin
         if (put_en) begin
            ids[tail] <= put_id;
            tail      <= tail + 1'b1;
         end
         if (take_en) head <= head + 1'b1;
         case ({put_en, take_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   assign next_id = ids[head];
   assign empty   = (count == '0);

   assert property (@(posedge clk) disable iff (!rstn) take_en |-> !empty)
      else $error("id_free_list: identifier taken from an empty pool");

endmodule

/* logic/spill_memory.sv */
`timescale 1ns/1ps
`include "spill_settings.svh"

module spill_memory (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  aw_valid,
   input  spill_pkg::mem_aw_t    aw,
   input  logic                  w_valid,
   input  spill_pkg::mem_w_t     w,
   input  logic                  b_ready,
   input  logic                  ar_valid,
   input  spill_pkg::mem_ar_t    ar,
   input  logic                  mem_load_valid,
   input  spill_pkg::mem_load_t  mem_load,
   output logic                  aw_ready,
   output logic                  w_ready,
   output logic                  b_valid,
   output spill_pkg::mem_b_t     b,
   output logic                  r_valid,
   output spill_pkg::mem_word_t  r_data
);

   localparam int WORDS = 1 << `MEM_LOG_WORDS;
   localparam int DLY   = `MEM_WRITE_DELAY - 1;   // The response queue adds one more

   spill_pkg::mem_word_t mem [WORDS];

   logic              burst_open;
   logic [15:0]       base_q;
   logic [7:0]        len_q;
   spill_pkg::mem_b_t id_q;
   logic [7:0]        beat_cnt;

   logic [15:0]       cur_base;
   logic [7:0]        cur_len;
   spill_pkg::mem_b_t cur_id;
   logic [7:0]        beat_idx;
   logic [15:0]       w_addr;

   logic [DLY-1:0]    dly_valid;
   spill_pkg::mem_b_t dly_id [DLY];
   logic              b_empty;

   assign aw_ready = !burst_open;
   assign w_ready  = 1'b1;

   // A beat may arrive in the same cycle as its address
   assign cur_base = burst_open ? base_q : aw.addr;
   assign cur_len  = burst_open ? len_q : aw.len;
   assign cur_id   = burst_open ? id_q : spill_pkg::mem_b_t'(aw.id);
   assign beat_idx = burst_open ? beat_cnt : 8'd0;
   assign w_addr   = cur_base + 16'(beat_idx);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         burst_open <= 1'b0;
         beat_cnt   <= '0;
         dly_valid  <= '0;
         r_valid    <= 1'b0;
      end else begin
         if (w_valid) begin
            burst_open <= !w.last;
            beat_cnt   <= w.last ? 8'd0 : beat_idx + 8'd1;
         end else if (aw_valid && aw_ready) begin
            burst_open <= 1'b1;
         end
         dly_valid[0] <= w_valid && w.last;
         for (int i = 1; i < DLY; i++) begin
            dly_valid[i] <= dly_valid[i-1];
         end
         r_valid <= ar_valid;   // Reads always accepted
      end
   end

   always_ff @(posedge clk) begin
      if (aw_valid && aw_ready) begin
         base_q <= aw.addr;
         len_q  <= aw.len;
         id_q   <= aw.id;
      end
      dly_id[0] <= cur_id;
      for (int i = 1; i < DLY; i++) begin
         dly_id[i] <= dly_id[i-1];
      end
      if (w_valid) mem[w_addr[`MEM_LOG_WORDS-1:0]] <= w.data;
      if (mem_load_valid) mem[mem_load.addr] <= mem_load.data;
      r_data <= mem[ar.addr[`MEM_LOG_WORDS-1:0]];
   end

   ////////////////////////////////////////
   // Responses wait here while b is stalled

   sync_fifo #(
      .WIDTH($bits(spill_pkg::mem_b_t)),
      .LOG_DEPTH(`LOG_ID_COUNT)
   ) resp_fifo (
      .clk(clk),
      .rstn(rstn),
      .wr_en(dly_valid[DLY-1]),
      .wr_data(dly_id[DLY-1]),
      .rd_en(b_valid && b_ready),
      .rd_data(b),
      .full(),
      .empty(b_empty),
      .size()
   );

   assign b_valid = !b_empty;

   // Each beat belongs to an open burst and last marks exactly its final beat
   assert property (@(posedge clk) disable iff (!rstn)
      w_valid |-> (burst_open || aw_valid) && (w.last == (beat_idx == cur_len)))
      else $error("spill_memory: beat count does not match burst length");

endmodule

/* logic/spill_pkg.sv */
`include "spill_settings.svh"

package spill_pkg;

   ////////////////////////////////////////
   // Task streams

   typedef struct packed {
      logic [31:0] ts;
      logic [15:0] locale;
      logic [3:0]  ttype;
   } task_t;

   typedef struct packed {
      logic [31:0] ts;
      logic [15:0] slot_id;
   } child_task_t;

   typedef logic [$bits(task_t)-1:0] mem_word_t;   // One spilled task per word

   ////////////////////////////////////////
   // Register port

   typedef struct packed {
      logic [7:0]  waddr;
      logic [31:0] wdata;
   } reg_wr_t;

   typedef struct packed {
      logic [31:0] rdata;
   } reg_rd_t;

   localparam logic [7:0] REG_START          = 8'h00;
   localparam logic [7:0] REG_SPILL_BASE     = 8'h04;
   localparam logic [7:0] REG_STACK_BASE     = 8'h08;
   localparam logic [7:0] REG_STACK_PTR_ADDR = 8'h0c;
   localparam logic [7:0] REG_NUM_ENQ        = 8'h10;
   localparam logic [7:0] REG_NUM_DEQ        = 8'h14;

   ////////////////////////////////////////
   // Memory channels

   typedef struct packed {
      logic [15:0]               addr;
      logic [7:0]                len;   // Beats minus one
      logic [`LOG_ID_COUNT-1:0]  id;
   } mem_aw_t;

   typedef struct packed {
      mem_word_t data;
      logic      last;
   } mem_w_t;

   typedef struct packed {
      logic [`LOG_ID_COUNT-1:0] id;
   } mem_b_t;

   typedef struct packed {
      logic [15:0] addr;
   } mem_ar_t;

   typedef struct packed {
      logic [`MEM_LOG_WORDS-1:0] addr;
      mem_word_t                 data;
   } mem_load_t;

endpackage

/* logic/spill_settings.svh */
`ifndef SPILL_SETTINGS_SVH
`define SPILL_SETTINGS_SVH

// Tasks written per splitter slot in a single burst
`define TASKS_PER_CHUNK 4
`define LOG_SPLITTERS_PER_CHUNK 2

`define LOG_SPILL_DEPTH 4
`define LOG_ID_COUNT 2

// Spill memory model
`define MEM_LOG_WORDS 8
`define MEM_WRITE_DELAY 2

// Child timestamp is the group minimum when set, else the first task's
`define MIN_TS_MODE 1

`endif

/* logic/spill_subsystem.sv */
`timescale 1ns/1ps

module spill_subsystem (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   overflow_valid,
   output logic                   overflow_ready,
   input  spill_pkg::task_t       overflow_task,
   output logic                   child_valid,
   input  logic                   child_ready,
   output spill_pkg::child_task_t child_task,
   input  logic                   reg_wvalid,
   input  spill_pkg::reg_wr_t     reg_wr,
   input  logic                   reg_arvalid,
   input  logic [7:0]             reg_araddr,
   output logic                   reg_rvalid,
   output spill_pkg::reg_rd_t     reg_rd,
   input  logic                   lock_in,
   output logic                   lock_out,
   input  logic                   mem_load_valid,
   input  spill_pkg::mem_load_t   mem_load
);

   logic                 aw_valid;
   logic                 aw_ready;
   spill_pkg::mem_aw_t   aw;
   logic                 w_valid;
   logic                 w_ready;
   spill_pkg::mem_w_t    w;
   logic                 b_valid;
   logic                 b_ready;
   spill_pkg::mem_b_t    b;
   logic                 ar_valid;
   spill_pkg::mem_ar_t   ar;
   logic                 r_valid;
   spill_pkg::mem_word_t r_data;

   task_coalescer coalescer (
      .clk(clk), .rstn(rstn),
      .overflow_valid(overflow_valid), .overflow_ready(overflow_ready),
      .overflow_task(overflow_task),
      .child_valid(child_valid), .child_ready(child_ready), .child_task(child_task),
      .reg_wvalid(reg_wvalid), .reg_wr(reg_wr),
      .reg_arvalid(reg_arvalid), .reg_araddr(reg_araddr),
      .reg_rvalid(reg_rvalid), .reg_rd(reg_rd),
      .lock_in(lock_in), .lock_out(lock_out),
      .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
      .w_valid(w_valid), .w_ready(w_ready), .w(w),
      .b_valid(b_valid), .b_ready(b_ready), .b(b),
      .ar_valid(ar_valid), .ar(ar),
      .r_valid(r_valid), .r_data(r_data)
   );

   // Stands in for the L1 cache
   spill_memory memory (
      .clk(clk), .rstn(rstn),
      .aw_valid(aw_valid), .aw(aw),
      .w_valid(w_valid), .w(w),
      .b_ready(b_ready),
      .ar_valid(ar_valid), .ar(ar),
      .mem_load_valid(mem_load_valid), .mem_load(mem_load),
      .aw_ready(aw_ready), .w_ready(w_ready),
      .b_valid(b_valid), .b(b),
      .r_valid(r_valid), .r_data(r_data)
   );

endmodule

/* logic/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
   parameter int WIDTH     = 8,
   parameter int LOG_DEPTH = 4
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               wr_en,
   input  logic [WIDTH-1:0]   wr_data,
   input  logic               rd_en,
   output logic [WIDTH-1:0]   rd_data,
   output logic               full,
   output logic               empty,
   output logic [LOG_DEPTH:0] size
);

   localparam int DEPTH = 1 << LOG_DEPTH;

   logic [WIDTH-1:0]     mem [DEPTH];
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH-1:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         size   <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   size <= size + 1'b1;
            2'b01:   size <= size - 1'b1;
            default: ;
         endcase
      end
   end

   assign rd_data = mem[rd_ptr];   // Head is visible without a read
   assign empty   = (size == '0);
   assign full    = (size == (LOG_DEPTH+1)'(DEPTH));

   assert property (@(posedge clk) disable iff (!rstn) wr_en |-> !full)
      else $error("sync_fifo: write while full");
   assert property (@(posedge clk) disable iff (!rstn) rd_en |-> !empty)
      else $error("sync_fifo: read while empty");

endmodule

/* logic/task_coalescer.sv */
`timescale 1ns/1ps
`include "spill_settings.svh"

module task_coalescer (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   overflow_valid,
   output logic                   overflow_ready,
   input  spill_pkg::task_t       overflow_task,
   output logic                   child_valid,
   input  logic                   child_ready,
   output spill_pkg::child_task_t child_task,
   input  logic                   reg_wvalid,
   input  spill_pkg::reg_wr_t     reg_wr,
   input  logic                   reg_arvalid,
   input  logic [7:0]             reg_araddr,
   output logic                   reg_rvalid,
   output spill_pkg::reg_rd_t     reg_rd,
   input  logic                   lock_in,
   output logic                   lock_out,
   output logic                   aw_valid,
   input  logic                   aw_ready,
   output spill_pkg::mem_aw_t     aw,
   output logic                   w_valid,
   input  logic                   w_ready,
   output spill_pkg::mem_w_t      w,
   input  logic                   b_valid,
   output logic                   b_ready,
   input  spill_pkg::mem_b_t      b,
   output logic                   ar_valid,
   output spill_pkg::mem_ar_t     ar,
   input  logic                   r_valid,
   input  spill_pkg::mem_word_t   r_data
);

   localparam int ID_COUNT  = 1 << `LOG_ID_COUNT;
   localparam int LOG_TPC   = $clog2(`TASKS_PER_CHUNK);
   localparam int SLOT_BITS = `LOG_SPLITTERS_PER_CHUNK;

   typedef enum logic [3:0] {
      S_INIT, S_GRAB_LOCK, S_CHECK_LOCK,
      S_READ_PTR, S_READ_PTR_WAIT,
      S_WRITE_PTR, S_PTR_WAIT,
      S_READ_TOP, S_READ_TOP_WAIT,
      S_RELEASE_LOCK, S_IDLE,
      S_WRITE_GROUP, S_WRITE_WAIT
   } state_t;

   state_t state;
   state_t state_next;
   logic [LOG_TPC:0] tasks_left;
   logic [LOG_TPC:0] tasks_left_next;

   logic                     start;
   logic [15:0]              spill_base;
   logic [15:0]              stack_base;
   logic [15:0]              ptr_addr;
   logic [31:0]              num_enq;
   logic [31:0]              num_deq;

   logic [15:0]              stack_ptr;
   logic [15:0]              slot_id;
   logic [31:0]              group_ts;
   logic [31:0]              group_ts_next;
   logic [`LOG_ID_COUNT-1:0] burst_id;
   logic [`LOG_ID_COUNT-1:0] ptr_id;
   logic [`LOG_ID_COUNT-1:0] next_id;
   logic                     id_empty;
   spill_pkg::child_task_t   pending [ID_COUNT];

   spill_pkg::task_t         spill_head;
   logic                     spill_full;
   logic                     spill_empty;
   logic                     spill_rd_en;
   logic                     child_full;
   logic                     child_empty;

   logic beat_fire;
   logic b_fire;
   logic ptr_resp;

   ////////////////////////////////////////
   // Spill FIFO and identifier pool

   assign overflow_ready = !spill_full;

   sync_fifo #(
      .WIDTH($bits(spill_pkg::task_t)),
      .LOG_DEPTH(`LOG_SPILL_DEPTH)
   ) spill_fifo (
      .clk(clk),
      .rstn(rstn),
      .wr_en(overflow_valid && overflow_ready),
      .wr_data(overflow_task),
      .rd_en(spill_rd_en),
      .rd_data(spill_head),
      .full(spill_full),
      .empty(spill_empty),
      .size()
   );

   id_free_list #(
      .LOG_COUNT(`LOG_ID_COUNT)
   ) id_pool (
      .clk(clk),
      .rstn(rstn),
      .put_en(b_fire),
      .put_id(b.id),
      .take_en(aw_valid && aw_ready),
      .next_id(next_id),
      .empty(id_empty)
   );

   ////////////////////////////////////////
   // Lock and burst FSM

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state      <= S_INIT;
         tasks_left <= '0;
         lock_out   <= 1'b0;
      end else begin
         state      <= state_next;
         tasks_left <= tasks_left_next;
         // The outside side wins a tie for the lock
         if (state == S_GRAB_LOCK && !lock_in) lock_out <= 1'b1;
         else if (state == S_CHECK_LOCK) lock_out <= !lock_in;
         else if (state == S_RELEASE_LOCK) lock_out <= 1'b0;
      end
   end

   assign beat_fire = (state == S_WRITE_GROUP) && w_valid && w_ready;

   always_comb begin
      group_ts_next = group_ts;
      if (tasks_left == (LOG_TPC+1)'(`TASKS_PER_CHUNK)) begin
         group_ts_next = spill_head.ts;
      end else if (`MIN_TS_MODE != 0 && spill_head.ts < group_ts) begin
         group_ts_next = spill_head.ts;
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_READ_PTR_WAIT && r_valid) stack_ptr <= r_data[15:0];
      if (state == S_READ_TOP_WAIT && r_valid) begin
         slot_id <= r_data[15:0] << SLOT_BITS;   // First slot of the new chunk
      end else if (state == S_WRITE_WAIT) begin
         slot_id <= slot_id + 16'd1;
      end
      if (aw_valid && aw_ready) begin
         if (state == S_WRITE_PTR) ptr_id <= next_id;
         else burst_id <= next_id;
      end
      if (beat_fire) group_ts <= group_ts_next;
      if (beat_fire && w.last) begin
         pending[burst_id] <= '{ts: group_ts_next, slot_id: slot_id};
      end
   end

   always_comb begin
      state_next      = state;
      tasks_left_next = tasks_left;
      spill_rd_en     = 1'b0;
      aw_valid        = 1'b0;
      aw              = '0;
      aw.id           = next_id;
      w_valid         = 1'b0;
      w               = '0;
      ar_valid        = 1'b0;
      ar              = '0;
      case (state)
         S_INIT: begin
            if (start && !spill_empty && !id_empty) state_next = S_GRAB_LOCK;
         end
         S_GRAB_LOCK: begin
            if (!lock_in) state_next = S_CHECK_LOCK;
         end
         S_CHECK_LOCK: begin
            state_next = lock_in ? S_GRAB_LOCK : S_READ_PTR;
         end
         S_READ_PTR: begin
            ar_valid   = 1'b1;
            ar.addr    = ptr_addr;
            state_next = S_READ_PTR_WAIT;
         end
         S_READ_PTR_WAIT: begin
            if (r_valid) state_next = S_WRITE_PTR;
         end
         S_WRITE_PTR: begin   // Single beat sent with its address
            aw_valid = 1'b1;
            aw.addr  = ptr_addr;
            w_valid  = 1'b1;
            w.data   = spill_pkg::mem_word_t'(stack_ptr + 16'd1);
            w.last   = 1'b1;
            if (aw_ready) state_next = S_PTR_WAIT;
         end
         S_PTR_WAIT: begin
            if (ptr_resp) state_next = S_READ_TOP;
         end
         S_READ_TOP: begin
            ar_valid   = 1'b1;
            ar.addr    = stack_base + stack_ptr;
            state_next = S_READ_TOP_WAIT;
         end
         S_READ_TOP_WAIT: begin
            if (r_valid) state_next = S_RELEASE_LOCK;
         end
         S_RELEASE_LOCK: begin
            state_next = S_IDLE;
         end
         S_IDLE: begin
            if (!start) begin
               state_next = S_INIT;
            end else if (!spill_empty && !id_empty) begin
               aw_valid        = 1'b1;
               aw.addr         = spill_base + (slot_id << LOG_TPC);
               aw.len          = 8'(`TASKS_PER_CHUNK - 1);
               tasks_left_next = (LOG_TPC+1)'(`TASKS_PER_CHUNK);
               if (aw_ready) state_next = S_WRITE_GROUP;
            end
         end
         S_WRITE_GROUP: begin
            if (!spill_empty) begin
               w_valid = 1'b1;
               w.data  = spill_head;
               w.last  = (tasks_left == 1);
               if (w_ready) begin
                  spill_rd_en     = 1'b1;
                  tasks_left_next = tasks_left - 1'b1;
                  if (tasks_left == 1) state_next = S_WRITE_WAIT;
               end
            end
         end
         S_WRITE_WAIT: begin   // Last slot of the chunk sends us back for a new one
            state_next = (slot_id[SLOT_BITS-1:0] == '1) ? S_INIT : S_IDLE;
         end
         default: state_next = S_INIT;
      endcase
   end

   ////////////////////////////////////////
   // Child tasks from write responses

   assign b_ready  = !child_full;
   assign b_fire   = b_valid && b_ready;
   assign ptr_resp = b_fire && (state == S_PTR_WAIT) && (b.id == ptr_id);

   sync_fifo #(
      .WIDTH($bits(spill_pkg::child_task_t)),
      .LOG_DEPTH(`LOG_SPILL_DEPTH)
   ) child_fifo (
      .clk(clk),
      .rstn(rstn),
      .wr_en(b_fire && !ptr_resp),
      .wr_data(pending[b.id]),
      .rd_en(child_valid && child_ready),
      .rd_data(child_task),
      .full(child_full),
      .empty(child_empty),
      .size()
   );

   assign child_valid = !child_empty;

   ////////////////////////////////////////
   // Registers and counters

   always_ff @(posedge clk) begin
      if (!rstn) begin
         start      <= 1'b0;
         num_enq    <= '0;
         num_deq    <= '0;
         reg_rvalid <= 1'b0;
      end else begin
         if (reg_wvalid && reg_wr.waddr == spill_pkg::REG_START) start <= reg_wr.wdata[0];
         if (child_valid && child_ready) num_enq <= num_enq + 32'd1;
         if (overflow_valid && overflow_ready) num_deq <= num_deq + 32'd1;
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_wvalid) begin
         case (reg_wr.waddr)
            spill_pkg::REG_SPILL_BASE:     spill_base <= reg_wr.wdata[15:0];
            spill_pkg::REG_STACK_BASE:     stack_base <= reg_wr.wdata[15:0];
            spill_pkg::REG_STACK_PTR_ADDR: ptr_addr   <= reg_wr.wdata[15:0];
            default: ;
         endcase
      end
      if (reg_arvalid) begin
         case (reg_araddr)
            spill_pkg::REG_NUM_ENQ: reg_rd.rdata <= num_enq;
            spill_pkg::REG_NUM_DEQ: reg_rd.rdata <= num_deq;
            default:                reg_rd.rdata <= 32'd0;
         endcase
      end
   end

   // A child keeps valid and its contents until it is taken
   assert property (@(posedge clk) disable iff (!rstn)
      child_valid && !child_ready |=> child_valid && $stable(child_task))
      else $error("task_coalescer: child dropped or changed before it was taken");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module spill_subsystem_tb \
   -f spill_subsystem.f \
   -o spill_subsystem_sim

./obj_dir/spill_subsystem_sim | tee sim.log

if grep -q "sim failed" sim.log; then
   echo "run_sim: testbench reported failures"
   exit 1
fi

echo "run_sim: no failures in sim.log"

/* sim/spill_subsystem_tb.sv */
`timescale 1ns/1ps
`include "spill_settings.svh"

module spill_subsystem_tb;

   localparam int TPC              = `TASKS_PER_CHUNK;
   localparam int SLOTS            = 1 << `LOG_SPLITTERS_PER_CHUNK;
   localparam int NUM_TESTS        = 5;
   localparam int GATE_CYCLES      = 20;
   localparam int QUIET_CYCLES     = 10;
   localparam int CYCLES_PER_GROUP = 200;

   // Pointer word first, then the stack, then the spill area
   localparam logic [15:0] PTR_ADDR   = 16'h0000;
   localparam logic [15:0] STACK_BASE = 16'h0008;
   localparam logic [15:0] SPILL_BASE = 16'h0020;

   typedef struct packed {
      logic [15:0] ptr;           // Stack pointer preload
      logic [15:0] entry;         // Stack entry of the first chunk
      int          groups;
      int          ready_stall;   // Cycles with child_ready low after start
      logic [7:0]  ready_mask;    // Repeating child_ready pattern after the stall
      int          lock_hold;     // Cycles lock_in stays high after start
      logic        expect_full;
   } test_row_t;

   logic                   clk = 1'b0;
   logic                   rstn;
   logic                   overflow_valid;
   logic                   overflow_ready;
   spill_pkg::task_t       overflow_task;
   logic                   child_valid;
   logic                   child_ready;
   spill_pkg::child_task_t child_task;
   logic                   reg_wvalid;
   spill_pkg::reg_wr_t     reg_wr;
   logic                   reg_arvalid;
   logic [7:0]             reg_araddr;
   logic                   reg_rvalid;
   spill_pkg::reg_rd_t     reg_rd;
   logic                   lock_in;
   logic                   lock_out;
   logic                   mem_load_valid;
   spill_pkg::mem_load_t   mem_load;

   string                  test_name [NUM_TESTS];
   test_row_t              rows [NUM_TESTS];
   spill_pkg::task_t       stim_tasks [128];
   spill_pkg::child_task_t exp_q [$];
   integer                 seed;
   int                     errors;
   int                     tests_passed;
   int                     tests_failed;
   logic                   saw_full;
   int                     lock_grabs;
   logic                   lock_seen;

   always #50 clk = ~clk;

   // One rising edge of lock_out per chunk taken from the stack
   always @(negedge clk) begin
      if (lock_out && !lock_seen) lock_grabs++;
      lock_seen = lock_out;
   end

   spill_subsystem dut (
      .clk(clk), .rstn(rstn),
      .overflow_valid(overflow_valid), .overflow_ready(overflow_ready),
      .overflow_task(overflow_task),
      .child_valid(child_valid), .child_ready(child_ready), .child_task(child_task),
      .reg_wvalid(reg_wvalid), .reg_wr(reg_wr),
      .reg_arvalid(reg_arvalid), .reg_araddr(reg_araddr),
      .reg_rvalid(reg_rvalid), .reg_rd(reg_rd),
      .lock_in(lock_in), .lock_out(lock_out),
      .mem_load_valid(mem_load_valid), .mem_load(mem_load)
   );

   ////////////////////////////////////////
   // Test table

   task automatic load_table();
      // Each row gives ptr, entry, groups, ready_stall, ready_mask, lock_hold and expect_full
      test_name[0] = "start_gate";
      rows[0]      = '{16'd0, 16'd1, 1, 0, 8'hff, 0, 1'b0};
      test_name[1] = "one_chunk";
      rows[1]      = '{16'd1, 16'd2, 4, 0, 8'b1011_0111, 0, 1'b0};
      test_name[2] = "new_chunk";
      rows[2]      = '{16'd2, 16'd0, 6, 0, 8'b1100_1101, 0, 1'b0};
      test_name[3] = "lock_held";
      rows[3]      = '{16'd0, 16'd3, 2, 0, 8'hff, 60, 1'b0};
      test_name[4] = "child_stall";
      rows[4]      = '{16'd1, 16'd1, 20, 700, 8'hff, 0, 1'b1};
   endtask

   // Chunks are spread apart so a plain slot increment would not match
   function automatic logic [15:0] chunk_entry(input int t, input int k);
      return rows[t].entry + 16'(2 * k);
   endfunction

   ////////////////////////////////////////
   // Bus helpers

   task automatic apply_reset(input int t);
      @(posedge clk);
      rstn           <= 1'b0;
      overflow_valid <= 1'b0;
      child_ready    <= 1'b0;
      reg_wvalid     <= 1'b0;
      reg_arvalid    <= 1'b0;
      lock_in        <= 1'b0;
      mem_load_valid <= 1'b0;
      repeat (2) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      assert (!child_valid && !lock_out && !reg_rvalid) else begin
         $display("test %s: outputs not idle after reset", test_name[t]);
         errors++;
      end
   endtask

   task automatic preload_word(input logic [15:0] addr, input logic [15:0] value);
      @(posedge clk);
      mem_load_valid <= 1'b1;
      mem_load       <= '{addr: addr[`MEM_LOG_WORDS-1:0], data: spill_pkg::mem_word_t'(value)};
      @(posedge clk);
      mem_load_valid <= 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      reg_wvalid <= 1'b1;
      reg_wr     <= '{waddr: addr, wdata: data};
      @(posedge clk);
      reg_wvalid <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
      @(posedge clk);
      reg_arvalid <= 1'b1;
      reg_araddr  <= addr;
      @(posedge clk);
      reg_arvalid <= 1'b0;
      @(negedge clk);   // Data is due exactly one cycle after the strobe
      assert (reg_rvalid) else begin
         $display("register read at %h returned no rvalid", addr);
         errors++;
      end
      data = reg_rd.rdata;
   endtask

   task automatic check_value(input int t, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
      assert (actual == expected) else begin
         $display("FAIL %s %s: expected %0h, actual %0h", test_name[t], what, expected, actual);
         errors++;
      end
   endtask

   ////////////////////////////////////////
   // Stimulus and response processes

   task automatic make_tasks(input int t);
      spill_pkg::child_task_t c;
      logic [31:0] ts;
      int idx;
      exp_q.delete();
      c = '0;
      for (int g = 0; g < rows[t].groups; g++) begin
         for (int i = 0; i < TPC; i++) begin
            idx = g * TPC + i;
            ts  = $random(seed);
            stim_tasks[idx] = '{ts: ts, locale: 16'(idx), ttype: 4'($random(seed))};
            if (i == 0 || (`MIN_TS_MODE != 0 && ts < c.ts)) c.ts = ts;
         end
         c.slot_id = (chunk_entry(t, g / SLOTS) << `LOG_SPLITTERS_PER_CHUNK) + 16'(g % SLOTS);
         exp_q.push_back(c);
      end
   endtask

   task automatic feed_tasks(input int count);
      int sent;
      sent = 0;
      while (sent < count) begin
         @(posedge clk);
         overflow_valid <= 1'b1;
         overflow_task  <= stim_tasks[sent];
         @(negedge clk);
         if (overflow_ready) sent++;
         else saw_full = 1'b1;
      end
      @(posedge clk);
      overflow_valid <= 1'b0;
   endtask

   task automatic check_start_gate(input int t);
      repeat (GATE_CYCLES) begin
         @(negedge clk);
         assert (!child_valid && !lock_out) else begin
            $display("test %s: child or lock request while start was 0", test_name[t]);
            errors++;
         end
      end
   endtask

   task automatic hold_lock(input int t, input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         assert (!child_valid && !lock_out) else begin
            $display("test %s: child or lock grant while lock_in was held", test_name[t]);
            errors++;
         end
      end
      @(posedge clk);
      lock_in <= 1'b0;
   endtask

   task automatic take_children(input int t, input int count, input int stall,
                                input logic [7:0] mask);
      spill_pkg::child_task_t want;
      int got;
      int cyc;
      got = 0;
      cyc = 0;
      while (got < count) begin
         @(posedge clk);
         child_ready <= (cyc >= stall) && mask[cyc % 8];
         cyc++;
         @(negedge clk);
         if (child_valid && child_ready) begin   // Transfer completes at the next edge
            want = exp_q.pop_front();
            check_value(t, $sformatf("child %0d slot_id", got), 32'(want.slot_id),
                        32'(child_task.slot_id));
            check_value(t, $sformatf("child %0d ts", got), want.ts, child_task.ts);
            got++;
         end
      end
      @(posedge clk);
      child_ready <= 1'b0;
   endtask

   task automatic run_test(input int t);
      test_row_t   r;
      int          n_tasks;
      int          chunks;
      int          errs_before;
      logic [31:0] value;
      r           = rows[t];
      errs_before = errors;
      n_tasks     = r.groups * TPC;
      chunks      = (r.groups + SLOTS - 1) / SLOTS;
      apply_reset(t);
      lock_grabs = 0;
      preload_word(PTR_ADDR, r.ptr);
      for (int k = 0; k < chunks; k++) begin
         preload_word(STACK_BASE + r.ptr + 16'(k), chunk_entry(t, k));
      end
      write_reg(spill_pkg::REG_SPILL_BASE, 32'(SPILL_BASE));
      write_reg(spill_pkg::REG_STACK_BASE, 32'(STACK_BASE));
      write_reg(spill_pkg::REG_STACK_PTR_ADDR, 32'(PTR_ADDR));
      make_tasks(t);
      saw_full = 1'b0;
      lock_in <= (r.lock_hold != 0);
      fork
         feed_tasks(n_tasks);
         begin
            check_start_gate(t);
            write_reg(spill_pkg::REG_START, 32'd1);
            fork
               hold_lock(t, r.lock_hold);
               take_children(t, r.groups, r.ready_stall, r.ready_mask);
            join
         end
      join
      repeat (QUIET_CYCLES) begin
         @(negedge clk);
         assert (!child_valid) else begin
            $display("test %s: extra child after the last expected one", test_name[t]);
            errors++;
         end
      end
      if (r.expect_full) begin
         assert (saw_full) else begin
            $display("test %s: overflow_ready never fell", test_name[t]);
            errors++;
         end
      end
      check_value(t, "lock grabs", 32'(chunks), 32'(lock_grabs));
      read_reg(spill_pkg::REG_NUM_DEQ, value);
      check_value(t, "num_deq", 32'(n_tasks), value);
      read_reg(spill_pkg::REG_NUM_ENQ, value);
      check_value(t, "num_enq", 32'(r.groups), value);
      if (errors == errs_before) begin
         $display("test %-12s ok", test_name[t]);
         tests_passed++;
      end else begin
         $display("test %-12s %0d errors", test_name[t], errors - errs_before);
         tests_failed++;
      end
   endtask

   task automatic watchdog(input int cycles);
      repeat (cycles) @(posedge clk);
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("sim failed");
      $finish;
   endtask

   initial begin
      int limit;
      rstn           = 1'b0;
      overflow_valid = 1'b0;
      overflow_task  = '0;
      child_ready    = 1'b0;
      reg_wvalid     = 1'b0;
      reg_wr         = '0;
      reg_arvalid    = 1'b0;
      reg_araddr     = '0;
      lock_in        = 1'b0;
      mem_load_valid = 1'b0;
      mem_load       = '0;
      seed           = 5177;
      errors         = 0;
      tests_passed   = 0;
      tests_failed   = 0;
      saw_full       = 1'b0;
      lock_grabs     = 0;
      lock_seen      = 1'b0;
      load_table();
      limit = 0;
      for (int t = 0; t < NUM_TESTS; t++) limit += CYCLES_PER_GROUP * rows[t].groups;
      fork
         watchdog(limit);
      join_none
      for (int t = 0; t < NUM_TESTS; t++) run_test(t);
      $display("%0d tests, %0d passed, %0d failed, %0d check errors",
               NUM_TESTS, tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* spill_subsystem.f */
+incdir+logic
logic/spill_pkg.sv
logic/sync_fifo.sv
logic/id_free_list.sv
logic/spill_memory.sv
logic/task_coalescer.sv
logic/spill_subsystem.sv
sim/spill_subsystem_tb.sv
